// ==== hdl/ringPkg.sv ====
package ringPkg;

	// ring slot fields
	typedef logic [15:0]  seqT;         // high byte is the node id
	typedef logic [15:0]  opmT;         // low byte is the opcode
	typedef logic [47:0]  ringAddrT;
	typedef logic [127:0] ringDataT;

	// mmio bus fields
	typedef logic [31:0]  mmioAddrT;
	typedef logic [63:0]  mmioDataT;

	localparam logic [7:0] opmIdle = 8'h00;
	localparam logic [7:0] opmLdsl = 8'h82;    // load long
	localparam logic [7:0] opmLdsq = 8'h83;    // load quad
	localparam logic [7:0] opmStsl = 8'h92;    // store long
	localparam logic [7:0] opmStsq = 8'h93;    // store quad

	// every response opcode carries 01 in bits 7:6
	localparam logic [7:0] opmOkld = 8'h60;

	typedef enum logic [4:0]
	{
		mmioReady = 5'h00,
		mmioRdQ   = 5'h01,
		mmioRdL   = 5'h02,
		mmioWrQ   = 5'h05,
		mmioWrL   = 5'h06
	} mmioOpT;

	typedef enum logic [1:0]
	{
		okReady = 2'b00,
		okOk    = 2'b01,
		okHold  = 2'b10
	} mmioOkT;

endpackage

// ==== hdl/ringSlotIf.sv ====
interface ringSlotIf;
	import ringPkg::*;

	seqT      seq;     // sequence tag
	opmT      opm;     // operation mode
	ringAddrT addr;
	ringDataT data;

	modport sender
	(
		output seq,
		output opm,
		output addr,
		output data
	);

	modport receiver
	(
		input seq,
		input opm,
		input addr,
		input data
	);

endinterface

// ==== hdl/mmioBusIf.sv ====
interface mmioBusIf;
	import ringPkg::*;

	mmioAddrT addr;
	mmioOpT   opm;
	mmioDataT outData;     // master to device
	mmioDataT inData;      // device to master
	mmioOkT   ok;

	modport master
	(
		output addr,
		output opm,
		output outData,
		input  inData,
		input  ok
	);

	modport device
	(
		input  addr,
		input  opm,
		input  outData,
		output inData,
		output ok
	);

endinterface

// ==== hdl/ringMmioBridge.sv ====
module ringMmioBridge #(
	parameter logic [7:0] bridgeNodeId = 8'h02
) (
	input logic         clock,
	input logic         reset,
	ringSlotIf.receiver ringIn,
	ringSlotIf.sender   ringOut,
	mmioBusIf.master    mmio
);
	import ringPkg::*;

	logic [7:0] inOpc;
	logic       inIsIdle;
	logic       inIsMmio;
	logic       inIsRsp;
	mmioOpT     inOp;

	logic       takeReq;
	logic       sendRsp;
	logic       dropRsp;
	logic       freeReq;

	// captured request
	seqT        reqSeq;
	opmT        reqOpm;
	ringAddrT   reqAddr;
	mmioDataT   reqData;
	mmioOpT     reqOp;
	logic       reqLive;

	logic       respDone;
	logic       respSent;
	mmioDataT   respData;

	mmioAddrT   mmioAddr1;
	mmioAddrT   mmioAddr2;
	mmioDataT   mmioData1;
	mmioDataT   mmioData2;
	mmioOpT     mmioOpm1;
	mmioOpT     mmioOpm2;
	mmioDataT   inDataQ;
	mmioOkT     okQ;

	seqT        nxtSeq;
	opmT        nxtOpm;
	ringAddrT   nxtAddr;
	ringDataT   nxtData;

	assign inOpc = ringIn.opm[7:0];
	assign inIsIdle = (inOpc == opmIdle);
	assign inIsRsp = (ringIn.opm[7:6] == 2'b01);

	always_comb
	begin
		inOp = mmioReady;
		case (inOpc)
			opmLdsq: inOp = mmioRdQ;
			opmLdsl: inOp = mmioRdL;
			opmStsq: inOp = mmioWrQ;
			opmStsl: inOp = mmioWrL;
			default: inOp = mmioReady;
		endcase
	end

	assign inIsMmio = (inOp != mmioReady);
	assign takeReq = inIsMmio && !reqLive;
	assign sendRsp = inIsIdle && respDone && !respSent;
	assign dropRsp = inIsRsp && (ringIn.seq[15:8] == bridgeNodeId);    // nothing to deliver here
	assign freeReq = respSent && (okQ == okReady);

	always_ff @(posedge clock)
	begin
		if (takeReq)
		begin
			reqSeq  <= ringIn.seq;
			reqOpm  <= ringIn.opm;
			reqAddr <= ringIn.addr;
			reqData <= ringIn.data[63:0];
			reqOp   <= inOp;
		end
		if (okQ == okOk && !respDone)
			respData <= (reqOp == mmioWrQ || reqOp == mmioWrL) ? '0 : inDataQ;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqLive  <= 1'b0;
			respDone <= 1'b0;
			respSent <= 1'b0;
		end
		else
		begin
			if (takeReq)
				reqLive <= 1'b1;
			if (okQ == okOk && reqLive)
				respDone <= 1'b1;
			if (sendRsp)
				respSent <= 1'b1;
			if (freeReq)
			begin
				reqLive  <= 1'b0;
				respDone <= 1'b0;
				respSent <= 1'b0;
			end
		end
	end

	// two output stages toward the bus, ok seen one cycle late
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mmioOpm1 <= mmioReady;
			mmioOpm2 <= mmioReady;
			okQ      <= okReady;
		end
		else
		begin
			mmioOpm2 <= mmioOpm1;
			okQ      <= mmio.ok;
			if (okQ == okOk || respDone)
				mmioOpm1 <= mmioReady;
			else if (okQ == okReady && reqLive)
				mmioOpm1 <= reqOp;
		end
	end

	always_ff @(posedge clock)
	begin
		inDataQ   <= mmio.inData;
		mmioAddr2 <= mmioAddr1;
		mmioData2 <= mmioData1;
		if (okQ == okReady && reqLive && !respDone)
		begin
			mmioAddr1 <= reqAddr[31:0];
			mmioData1 <= reqData;
		end
	end

	assign mmio.addr    = mmioAddr2;
	assign mmio.opm     = mmioOpm2;
	assign mmio.outData = mmioData2;

	always_comb
	begin
		nxtSeq  = ringIn.seq;
		nxtOpm  = ringIn.opm;
		nxtAddr = ringIn.addr;
		nxtData = ringIn.data;
		if (takeReq || dropRsp)
		begin
			nxtSeq  = '0;
			nxtOpm  = {8'h00, opmIdle};
			nxtAddr = '0;
			nxtData = '0;
		end
		else if (sendRsp)
		begin
			nxtSeq  = reqSeq;
			nxtOpm  = {reqOpm[15:8], opmOkld};
			nxtAddr = reqAddr;
			nxtData = {64'h0, respData};
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			ringOut.opm <= {8'h00, opmIdle};
		else
			ringOut.opm <= nxtOpm;
	end

	always_ff @(posedge clock)
	begin
		ringOut.seq  <= nxtSeq;
		ringOut.addr <= nxtAddr;
		ringOut.data <= nxtData;
	end

endmodule

// ==== hdl/ringRequester.sv ====
module ringRequester #(
	parameter logic [7:0] nodeId = 8'h01
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              reqStrobe,
	input  logic              reqWrite,
	input  logic              reqLong,
	input  ringPkg::ringAddrT reqAddr,
	input  ringPkg::mmioDataT reqData,
	output logic              reqBusy,
	output logic              rspValid,
	output ringPkg::seqT      rspSeq,
	output ringPkg::mmioDataT rspData,
	ringSlotIf.receiver       ringIn,
	ringSlotIf.sender         ringOut
);
	import ringPkg::*;

	// two slots on the ring, one is kept free for the bridge response
	localparam int maxInFlight = 2;

	logic       accept;
	logic       inject;
	logic       ownRsp;
	logic [7:0] seqCount;
	logic [1:0] inFlight;

	seqT        pendSeq;
	opmT        pendOpm;
	ringAddrT   pendAddr;
	mmioDataT   pendData;

	seqT        nxtSeq;
	opmT        nxtOpm;
	ringAddrT   nxtAddr;
	ringDataT   nxtData;

	assign accept = reqStrobe && !reqBusy;
	assign inject = reqBusy && (ringIn.opm[7:0] == opmIdle) && (inFlight < 2'(maxInFlight));
	assign ownRsp = (ringIn.opm[7:6] == 2'b01) && (ringIn.seq[15:8] == nodeId);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqBusy  <= 1'b0;
			rspValid <= 1'b0;
			seqCount <= '0;
			inFlight <= '0;
			ringOut.opm <= {8'h00, opmIdle};
		end
		else
		begin
			rspValid <= ownRsp;
			ringOut.opm <= nxtOpm;
			if (accept)
			begin
				reqBusy  <= 1'b1;
				seqCount <= seqCount + 8'd1;
			end
			else if (inject)
				reqBusy <= 1'b0;
			if (inject)
				inFlight <= inFlight + 2'd1;
			else if (ownRsp)
				inFlight <= inFlight - 2'd1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			pendSeq  <= {nodeId, seqCount};
			pendOpm  <= {8'h00, reqWrite ? (reqLong ? opmStsl : opmStsq)
				: (reqLong ? opmLdsl : opmLdsq)};
			pendAddr <= reqAddr;
			pendData <= reqData;
		end
		if (ownRsp)
		begin
			rspSeq  <= ringIn.seq;
			rspData <= ringIn.data[63:0];
		end
		ringOut.seq  <= nxtSeq;
		ringOut.addr <= nxtAddr;
		ringOut.data <= nxtData;
	end

	always_comb
	begin
		nxtSeq  = ringIn.seq;    // everything else goes around again
		nxtOpm  = ringIn.opm;
		nxtAddr = ringIn.addr;
		nxtData = ringIn.data;
		if (inject)
		begin
			nxtSeq  = pendSeq;
			nxtOpm  = pendOpm;
			nxtAddr = pendAddr;
			nxtData = {64'h0, pendData};
		end
		else if (ownRsp)
		begin
			nxtSeq  = '0;
			nxtOpm  = {8'h00, opmIdle};
			nxtAddr = '0;
			nxtData = '0;
		end
	end

endmodule

// ==== hdl/mmioRegBlock.sv ====
module mmioRegBlock #(
	parameter int                waitCycles = 3,
	parameter ringPkg::mmioAddrT regBase    = 32'h0000_0000
) (
	input logic      clock,
	input logic      reset,
	mmioBusIf.device mmio
);
	import ringPkg::*;

	mmioDataT   regs [16];
	mmioAddrT   regOffset;
	logic [3:0] regIdx;
	logic [7:0] waitCount;
	logic       startOp;
	logic       finishOp;
	mmioOkT     okState;

	assign regOffset = mmio.addr - regBase;
	assign regIdx = regOffset[6:3];    // one quad per register

	assign startOp = (okState == okReady) && (mmio.opm != mmioReady);
	assign finishOp = (startOp && waitCycles == 0) ||
		((okState == okHold) && (waitCount <= 8'd1));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			okState   <= okReady;
			waitCount <= '0;
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end
		else
		begin
			case (okState)
				okReady:
				begin
					if (startOp)
					begin
						waitCount <= 8'(waitCycles);
						okState   <= (waitCycles == 0) ? okOk : okHold;
					end
				end
				okHold:
				begin
					waitCount <= waitCount - 8'd1;
					if (waitCount <= 8'd1)
						okState <= okOk;
				end
				default:
				begin
					if (mmio.opm == mmioReady)    // master has seen ok
						okState <= okReady;
				end
			endcase
			if (finishOp && mmio.opm == mmioWrQ)
				regs[regIdx] <= mmio.outData;
			if (finishOp && mmio.opm == mmioWrL)
				regs[regIdx][31:0] <= mmio.outData[31:0];    // high half kept
		end
	end

	always_ff @(posedge clock)
	begin
		if (finishOp)
		begin
			case (mmio.opm)
				mmioRdQ: mmio.inData <= regs[regIdx];
				mmioRdL: mmio.inData <= {32'h0, regs[regIdx][31:0]};
				default: mmio.inData <= '0;
			endcase
		end
	end

	assign mmio.ok = okState;

endmodule

// ==== hdl/ringMmioTop.sv ====
module ringMmioTop #(
	parameter logic [7:0]        requesterId = 8'h01,
	parameter logic [7:0]        bridgeId    = 8'h02,
	parameter int                waitCycles  = 3,
	parameter ringPkg::mmioAddrT regBase     = 32'h0000_0000
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              reqStrobe,
	input  logic              reqWrite,
	input  logic              reqLong,
	input  ringPkg::ringAddrT reqAddr,
	input  ringPkg::mmioDataT reqData,
	output logic              reqBusy,
	output logic              rspValid,
	output ringPkg::seqT      rspSeq,
	output ringPkg::mmioDataT rspData
);

	ringSlotIf ringA();    // requester to bridge
	ringSlotIf ringB();    // bridge back to requester
	mmioBusIf  mmioBus();

	ringRequester #(
		.nodeId(requesterId)
	) i_requester (
		.clock(clock),
		.reset(reset),
		.reqStrobe(reqStrobe),
		.reqWrite(reqWrite),
		.reqLong(reqLong),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqBusy(reqBusy),
		.rspValid(rspValid),
		.rspSeq(rspSeq),
		.rspData(rspData),
		.ringIn(ringB.receiver),
		.ringOut(ringA.sender)
	);

	ringMmioBridge #(
		.bridgeNodeId(bridgeId)
	) i_bridge (
		.clock(clock),
		.reset(reset),
		.ringIn(ringA.receiver),
		.ringOut(ringB.sender),
		.mmio(mmioBus.master)
	);

	mmioRegBlock #(
		.waitCycles(waitCycles),
		.regBase(regBase)
	) i_regBlock (
		.clock(clock),
		.reset(reset),
		.mmio(mmioBus.device)
	);

endmodule

// ==== dv/ringMmio_sva.sv ====
module ringMmioSva
(
	input logic            clock,
	input logic            reset,
	input logic            reqBusy,
	input logic            rspValid,
	input ringPkg::mmioOpT mmioOpm,
	input ringPkg::mmioOkT mmioOk
);
	timeunit 1ns;
	timeprecision 1ps;

	import ringPkg::*;

	// bus and top outputs come out of reset idle
	resetState: assert property (@(posedge clock)
		reset |=> (mmioOpm == mmioReady && mmioOk == okReady && !reqBusy && !rspValid))
		else $error("MMIO bus or top outputs not idle after reset");

	rspPulse: assert property (@(posedge clock) disable iff (reset)
		rspValid |=> !rspValid)
		else $error("rspValid held longer than one cycle");

	// opm may not change before the device answers ok
	opmStable: assert property (@(posedge clock) disable iff (reset)
		(mmioOpm != mmioReady && mmioOk != okOk) |=> $stable(mmioOpm))
		else $error("MMIO opm changed before okOk");

	noEarlyStart: assert property (@(posedge clock) disable iff (reset)
		(mmioOpm != mmioReady && $past(mmioOpm) == mmioReady) |-> mmioOk == okReady)
		else $error("MMIO operation started while ok was not ready");

endmodule

bind ringMmioTop ringMmioSva i_sva
(
	.clock(clock),
	.reset(reset),
	.reqBusy(reqBusy),
	.rspValid(rspValid),
	.mmioOpm(mmioBus.opm),
	.mmioOk(mmioBus.ok)
);

// ==== dv/ringMmioTb.sv ====
module ringMmioTb;
	timeunit 1ns;
	timeprecision 1ps;

	import ringPkg::*;

	localparam logic [7:0] requesterId = 8'h01;
	localparam mmioAddrT   regBase     = 32'h0000_4000;
	localparam int         burstLen    = 40;
	localparam int         totalReqs   = 6 + burstLen;

	logic       clock;
	logic       reset;
	logic       reqStrobe;
	logic       reqWrite;
	logic       reqLong;
	ringAddrT   reqAddr;
	mmioDataT   reqData;
	logic       reqBusy;
	logic       rspValid;
	seqT        rspSeq;
	mmioDataT   rspData;

	mmioDataT   model [16];       // reference copy of the registers
	mmioDataT   expData [256];    // by seq count
	logic [3:0] seqReg [256];
	logic       seqOpen [256];
	int         regIssued [16];
	int         regDone [16];
	int         issuedCount;
	int         doneCount;
	integer     seed;

	ringMmioTop #(
		.requesterId(requesterId),
		.bridgeId(8'h02),
		.waitCycles(3),
		.regBase(regBase)
	) i_dut (
		.clock(clock),
		.reset(reset),
		.reqStrobe(reqStrobe),
		.reqWrite(reqWrite),
		.reqLong(reqLong),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqBusy(reqBusy),
		.rspValid(rspValid),
		.rspSeq(rspSeq),
		.rspData(rspData)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic reportFail(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic issueReq(input logic wr, input logic lng, input logic [3:0] idx,
		input mmioDataT data);
		logic [7:0] cnt;
		cnt = 8'(issuedCount);
		@(posedge clock);
		while (reqBusy)
			@(posedge clock);
		reqStrobe <= 1'b1;
		reqWrite  <= wr;
		reqLong   <= lng;
		reqAddr   <= {16'h0, regBase + mmioAddrT'({idx, 3'b000})};
		reqData   <= data;
		if (wr)
		begin
			expData[cnt] = '0;    // stores answer with zero
			if (lng)
				model[idx][31:0] = data[31:0];
			else
				model[idx] = data;
		end
		else if (lng)
			expData[cnt] = {32'h0, model[idx][31:0]};
		else
			expData[cnt] = model[idx];
		seqReg[cnt]  = idx;
		seqOpen[cnt] = 1'b1;
		regIssued[idx]++;
		issuedCount++;
		@(posedge clock);
		reqStrobe <= 1'b0;
	endtask

	task automatic waitIdle();
		while (doneCount != issuedCount)
			@(posedge clock);
	endtask

	task automatic checkResponse(input seqT seq, input mmioDataT data);
		logic [7:0] cnt;
		cnt = seq[7:0];
		assert (seq[15:8] == requesterId)
		else
			reportFail($sformatf("ERR %0t rspSeq node id expected %h got %h",
				$time, requesterId, seq[15:8]));
		assert (seqOpen[cnt] === 1'b1)
		else
			reportFail($sformatf("response arrived for seq %h, which is not outstanding", seq));
		assert (data === expData[cnt])
		else
			reportFail($sformatf("ERR %0t rspData expected %h got %h",
				$time, expData[cnt], data));
		seqOpen[cnt] = 1'b0;
		regDone[seqReg[cnt]]++;
		doneCount++;
	endtask

	always @(negedge clock)
	begin
		if (!reset && rspValid)
			checkResponse(rspSeq, rspData);
	end

	// 200 cycles per request plus reset
	initial
	begin
		repeat (200 * totalReqs + 20)
			@(posedge clock);
		reportFail("timeout: not all ring responses came back in time");
	end

	initial
	begin
		logic [3:0] idx;
		logic       wr;
		logic       lng;
		mmioDataT   value;
		seed = 5589;
		issuedCount = 0;
		doneCount = 0;
		foreach (model[i])
		begin
			model[i]     = '0;
			regIssued[i] = 0;
			regDone[i]   = 0;
		end
		foreach (seqOpen[i])
			seqOpen[i] = 1'b0;
		reset     <= 1'b1;
		reqStrobe <= 1'b0;
		reqWrite  <= 1'b0;
		reqLong   <= 1'b0;
		reqAddr   <= '0;
		reqData   <= '0;
		repeat (2)
			@(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		assert (reqBusy === 1'b0 && rspValid === 1'b0)
		else
			reportFail($sformatf("ERR %0t reqBusy/rspValid expected 0/0 got %b/%b",
				$time, reqBusy, rspValid));

		// quad store then quad read
		value = {$random(seed), $random(seed)};
		issueReq(1'b1, 1'b0, 4'd3, value);
		waitIdle();
		issueReq(1'b0, 1'b0, 4'd3, '0);
		waitIdle();

		// long store keeps the high half
		issueReq(1'b1, 1'b0, 4'd5, {$random(seed), $random(seed)});
		waitIdle();
		issueReq(1'b1, 1'b1, 4'd5, {$random(seed), $random(seed)});
		waitIdle();
		issueReq(1'b0, 1'b0, 4'd5, '0);
		waitIdle();
		issueReq(1'b0, 1'b1, 4'd5, '0);
		waitIdle();

		// back-to-back requests keep the bridge busy so they circle
		repeat (burstLen)
		begin
			wr  = 1'($random(seed));
			lng = 1'($random(seed));
			idx = 4'($random(seed));
			while (regIssued[idx] != regDone[idx])
				idx = idx + 4'd1;    // in-flight requests on separate registers
			value = {$random(seed), $random(seed)};
			issueReq(wr, lng, idx, value);
		end
		waitIdle();
		repeat (4)
			@(posedge clock);

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== project.f ====
hdl/ringPkg.sv
hdl/ringSlotIf.sv
hdl/mmioBusIf.sv
hdl/ringMmioBridge.sv
hdl/ringRequester.sv
hdl/mmioRegBlock.sv
hdl/ringMmioTop.sv
dv/ringMmio_sva.sv
dv/ringMmioTb.sv

// ==== Bender.yml ====
package:
  name: ring_mmio

sources:
  - hdl/ringPkg.sv
  - hdl/ringSlotIf.sv
  - hdl/mmioBusIf.sv
  - hdl/ringMmioBridge.sv
  - hdl/ringRequester.sv
  - hdl/mmioRegBlock.sv
  - hdl/ringMmioTop.sv
  - target: test
    files:
      - dv/ringMmio_sva.sv
      - dv/ringMmioTb.sv
